// File: verilog/riscv_pma_pkg.sv
/* Sizes and types for the physical memory attribute stage. Table address words hold
   the address shifted right by 2 (word units). XLEN and PLEN are assumed equal. */
`default_nettype none

package riscv_pma_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  // Address register width
  localparam int XLEN      = 32;
  // Physical address width
  localparam int PLEN      = 32;
  // Attribute table depth
  localparam int PMA_CNT   = 4;
  localparam int PMA_IDX_W = 2;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    MEM_TYPE_EMPTY,
    MEM_TYPE_MAIN,
    MEM_TYPE_IO,
    MEM_TYPE_TCM
  } mem_type_t;

  // Carried in the config word, not checked here
  typedef enum logic [1:0] {
    AMO_TYPE_NONE,
    AMO_TYPE_SWAP,
    AMO_TYPE_LOGICAL,
    AMO_TYPE_ARITH
  } amo_type_t;

  // Region address matching
  typedef enum logic [1:0] {
    OFF,
    TOR,
    NA4,
    NAPOT
  } match_mode_t;

  // Codes above QWORD are treated as a single byte
  typedef enum logic [2:0] {
    BYTE  = 3'd0,
    HWORD = 3'd1,
    WORD  = 3'd2,
    DWORD = 3'd3,
    QWORD = 3'd4
  } xfer_size_t;

  //////////////////////////////////////////////////
  // Structures
  //////////////////////////////////////////////////

  // 14-bit attribute word, mem_type in bits 13:12
  typedef struct packed {
    mem_type_t   mem_type;
    logic        r;
    logic        w;
    logic        x;
    logic        cacheable;
    logic        coherent;
    logic        idem_rd;
    logic        idem_wr;
    logic        misalign_ok;
    amo_type_t   amo_type;
    match_mode_t mode;
  } pma_cfg_t;

  localparam int PMA_CFG_W = $bits(pma_cfg_t);

  // Table entry after reset
  localparam pma_cfg_t PMA_CFG_RST = '{
    mem_type:    MEM_TYPE_EMPTY,
    r:           1'b0,
    w:           1'b0,
    x:           1'b0,
    cacheable:   1'b0,
    coherent:    1'b0,
    idem_rd:     1'b0,
    idem_wr:     1'b0,
    misalign_ok: 1'b0,
    amo_type:    AMO_TYPE_NONE,
    mode:        OFF
  };

  // Physical access request
  typedef struct packed {
    logic            req;
    logic            instr;
    logic            we;
    xfer_size_t      size;
    logic [PLEN-1:0] adr;
  } pma_req_t;

  // Registered check result
  typedef struct packed {
    logic     valid;
    pma_cfg_t pma;
    logic     exception;
    logic     misaligned;
    logic     is_cache;
    logic     is_ext;
    logic     is_tcm;
  } pma_resp_t;

endpackage

`default_nettype wire

// File: verilog/riscv_pma_regs.sv
/* Attribute table, raw config words only (no sanitizing here).
   No read-back; both strobes in one cycle write both words. */
`default_nettype none

module riscv_pma_regs
  import riscv_pma_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  // Config write port
  input  logic                          cfg_wr_cfg_i,
  input  logic                          cfg_wr_adr_i,
  input  logic [PMA_IDX_W-1:0]          cfg_idx_i,
  input  logic [XLEN-1:0]               cfg_wdata_i,

  // Table out to the checker
  output pma_cfg_t [PMA_CNT-1:0]        pma_cfg_o,
  output logic [PMA_CNT-1:0][XLEN-1:0]  pma_adr_o
);

  //////////////////////////////////////////////////
  // Config words
  //////////////////////////////////////////////////

  // Low bits of the write data only
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // Every entry back to OFF / EMPTY
      for (int i = 0; i < PMA_CNT; i++) begin
        pma_cfg_o[i] <= PMA_CFG_RST;
      end
    end else if (cfg_wr_cfg_i) begin
      pma_cfg_o[cfg_idx_i] <= pma_cfg_t'(cfg_wdata_i[PMA_CFG_W-1:0]);
    end
  end

  //////////////////////////////////////////////////
  // Address words
  //////////////////////////////////////////////////

  // Full word, word-unit address
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pma_adr_o <= '0;
    end else if (cfg_wr_adr_i) begin
      pma_adr_o[cfg_idx_i] <= cfg_wdata_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/riscv_misalign_det.sv
/* Alignment check against the transfer size; sizes above QWORD never flag. */
`default_nettype none

module riscv_misalign_det
  import riscv_pma_pkg::*;
(
  input  pma_req_t req_i,
  output logic     misaligned_o
);

  // Low address bits that must be zero
  logic [3:0] align_mask;

  always_comb begin
    case (req_i.size)
      HWORD:   align_mask = 4'b0001;
      WORD:    align_mask = 4'b0011;
      DWORD:   align_mask = 4'b0111;
      QWORD:   align_mask = 4'b1111;
      // BYTE and unused codes
      default: align_mask = 4'b0000;
    endcase
  end

  // Only while a request is up
  assign misaligned_o = req_i.req & |(req_i.adr[3:0] & align_mask);

endmodule

`default_nettype wire

// File: verilog/riscv_pmachk.sv
/* Combinational attribute check; lowest entry fully holding the access wins, entry 0
   if none. Access end wraps at the top of the address space. Lock/AMO is not checked. */
`default_nettype none

module riscv_pmachk
  import riscv_pma_pkg::*;
(
  // Attribute table
  input  pma_cfg_t [PMA_CNT-1:0]        pma_cfg_i,
  input  logic [PMA_CNT-1:0][XLEN-1:0]  pma_adr_i,

  // Access
  input  pma_req_t                      req_i,
  input  logic                          misaligned_i,

  // Result
  output pma_cfg_t                      pma_o,
  output logic                          exception_o,
  output logic                          misaligned_o,
  output logic                          is_cache_access_o,
  output logic                          is_ext_access_o,
  output logic                          is_tcm_access_o
);

  //////////////////////////////////////////////////
  // Functions
  //////////////////////////////////////////////////

  // Bytes per transfer
  function automatic logic [PLEN-1:0] xfer_bytes(input xfer_size_t size);
    case (size)
      HWORD:   return PLEN'(2);
      WORD:    return PLEN'(4);
      DWORD:   return PLEN'(8);
      QWORD:   return PLEN'(16);
      default: return PLEN'(1);
    endcase
  endfunction

  // NAPOT region is 2^n words, n = trailing ones + 1
  function automatic int napot_log(input logic [PLEN-3:0] adr_w);
    int   n;
    logic run;
    n   = 1;
    run = 1'b1;
    for (int i = 0; i < PLEN-2; i++) begin
      if (run && adr_w[i]) begin
        n++;
      end else begin
        run = 1'b0;
      end
    end
    return n;
  endfunction

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  pma_cfg_t             cfg_s  [PMA_CNT];
  logic [PLEN-3:0]      pma_lb [PMA_CNT];
  logic [PLEN-3:0]      pma_ub [PMA_CNT];
  logic [PMA_CNT-1:0]   match_all;
  logic [PMA_IDX_W-1:0] match_idx;
  logic [PLEN-1:0]      access_lb;
  logic [PLEN-1:0]      access_ub;
  pma_cfg_t             cfg_m;
  logic                 access_ok;

  // First and last byte of the access
  assign access_lb = req_i.adr;
  assign access_ub = req_i.adr + xfer_bytes(req_i.size) - PLEN'(1);

  //////////////////////////////////////////////////
  // Per entry: sanitize, bounds, match
  //////////////////////////////////////////////////

  for (genvar i = 0; i < PMA_CNT; i++) begin : gen_entry
    logic [PLEN-3:0] adr_w;
    logic [5:0]      sz_log;
    logic [PLEN-3:0] napot_mask;
    logic [PLEN-3:0] tor_lb;

    // Clean up fields the memory type does not allow
    always_comb begin
      cfg_s[i] = pma_cfg_i[i];
      if (pma_cfg_i[i].mem_type == MEM_TYPE_EMPTY) begin
        cfg_s[i].mem_type = MEM_TYPE_IO;
        cfg_s[i].amo_type = AMO_TYPE_NONE;
        cfg_s[i].r        = 1'b0;
        cfg_s[i].w        = 1'b0;
        cfg_s[i].x        = 1'b0;
      end
      // Cacheable only for main memory, coherent needs cacheable
      cfg_s[i].cacheable = pma_cfg_i[i].cacheable & (pma_cfg_i[i].mem_type == MEM_TYPE_MAIN);
      cfg_s[i].coherent  = pma_cfg_i[i].coherent & cfg_s[i].cacheable;
      // Idempotent unless IO (raw type)
      if (pma_cfg_i[i].mem_type != MEM_TYPE_IO) begin
        cfg_s[i].idem_rd = 1'b1;
        cfg_s[i].idem_wr = 1'b1;
      end
    end

    assign adr_w      = pma_adr_i[i][PLEN-3:0];
    assign sz_log     = 6'(napot_log(adr_w));
    assign napot_mask = {(PLEN-2){1'b1}} << sz_log;

    // TOR starts where the entry below ends
    if (i == 0) begin : gen_first
      assign tor_lb = '0;
    end else begin : gen_next
      assign tor_lb = pma_ub[i-1];
    end

    // Bounds in words, upper exclusive
    always_comb begin
      case (cfg_s[i].mode)
        TOR: begin
          pma_lb[i] = tor_lb;
          pma_ub[i] = adr_w;
        end
        NA4: begin
          pma_lb[i] = adr_w;
          pma_ub[i] = adr_w + 1'b1;
        end
        NAPOT: begin
          pma_lb[i] = adr_w & napot_mask;
          pma_ub[i] = (adr_w + ({{(PLEN-3){1'b0}}, 1'b1} << sz_log)) & napot_mask;
        end
        // OFF still exports its address as the next TOR base
        default: begin
          pma_lb[i] = '0;
          pma_ub[i] = adr_w;
        end
      endcase
    end

    // All bytes inside the region
    assign match_all[i] = (cfg_s[i].mode != OFF) &&
                          (access_lb[PLEN-1:2] >= pma_lb[i]) &&
                          (access_ub[PLEN-1:2] <  pma_ub[i]);
  end

  //////////////////////////////////////////////////
  // Priority and result
  //////////////////////////////////////////////////

  // Lowest index wins, default entry 0
  always_comb begin
    match_idx = '0;
    for (int i = PMA_CNT-1; i >= 0; i--) begin
      if (match_all[i]) begin
        match_idx = PMA_IDX_W'(i);
      end
    end
  end

  assign cfg_m = cfg_s[match_idx];
  assign pma_o = cfg_m;

  // No region, or permission missing
  assign exception_o = req_i.req & (~|match_all                  |
                                    (req_i.instr & ~cfg_m.x)     |
                                    (req_i.we    & ~cfg_m.w)     |
                                    (~req_i.we   & ~cfg_m.r));

  assign misaligned_o = misaligned_i & ~cfg_m.misalign_ok;

  // Access type only for a clean access
  assign access_ok         = req_i.req & ~exception_o & ~misaligned_o;
  assign is_cache_access_o = access_ok & cfg_m.cacheable;
  assign is_tcm_access_o   = access_ok & (cfg_m.mem_type == MEM_TYPE_TCM);
  assign is_ext_access_o   = access_ok & ~cfg_m.cacheable & (cfg_m.mem_type != MEM_TYPE_TCM);

endmodule

`default_nettype wire

// File: verilog/riscv_pma_unit.sv
/* PMA stage top; response one cycle after each request, no back-pressure.
   Table writes are seen by a request in the next cycle. */
`default_nettype none

module riscv_pma_unit
  import riscv_pma_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Config write port
  input  logic                 cfg_wr_cfg_i,
  input  logic                 cfg_wr_adr_i,
  input  logic [PMA_IDX_W-1:0] cfg_idx_i,
  input  logic [XLEN-1:0]      cfg_wdata_i,

  // Access in, result out
  input  pma_req_t             req_i,
  output pma_resp_t            resp_o
);

  pma_cfg_t [PMA_CNT-1:0]       pma_cfg;
  logic [PMA_CNT-1:0][XLEN-1:0] pma_adr;
  logic                         misaligned;
  pma_resp_t                    resp_d;

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////

  riscv_pma_regs i_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cfg_wr_cfg_i (cfg_wr_cfg_i),
    .cfg_wr_adr_i (cfg_wr_adr_i),
    .cfg_idx_i    (cfg_idx_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .pma_cfg_o    (pma_cfg),
    .pma_adr_o    (pma_adr)
  );

  riscv_misalign_det i_misalign (
    .req_i        (req_i),
    .misaligned_o (misaligned)
  );

  riscv_pmachk i_chk (
    .pma_cfg_i         (pma_cfg),
    .pma_adr_i         (pma_adr),
    .req_i             (req_i),
    .misaligned_i      (misaligned),
    .pma_o             (resp_d.pma),
    .exception_o       (resp_d.exception),
    .misaligned_o      (resp_d.misaligned),
    .is_cache_access_o (resp_d.is_cache),
    .is_ext_access_o   (resp_d.is_ext),
    .is_tcm_access_o   (resp_d.is_tcm)
  );

  assign resp_d.valid = req_i.req;

  //////////////////////////////////////////////////
  // Response register
  //////////////////////////////////////////////////

  // Valid and flags
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_o.valid      <= 1'b0;
      resp_o.exception  <= 1'b0;
      resp_o.misaligned <= 1'b0;
      resp_o.is_cache   <= 1'b0;
      resp_o.is_ext     <= 1'b0;
      resp_o.is_tcm     <= 1'b0;
    end else begin
      resp_o.valid      <= resp_d.valid;
      resp_o.exception  <= resp_d.exception;
      resp_o.misaligned <= resp_d.misaligned;
      resp_o.is_cache   <= resp_d.is_cache;
      resp_o.is_ext     <= resp_d.is_ext;
      resp_o.is_tcm     <= resp_d.is_tcm;
    end
  end

  // Matched attributes, loaded every cycle
  always_ff @(posedge clk_i) begin
    resp_o.pma <= resp_d.pma;
  end

endmodule

`default_nettype wire

// File: verification/tb_clk_gen.sv
/* Testbench clock, period 10, and reset held low for 3 cycles.
   Reset is released 1 time unit after a rising edge. */
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Half period of 5
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Low for the first 3 rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: include/pma_ref_model.svh
/* Expected response from a shadow table and a request. The including module
   imports riscv_pma_pkg; the pma field is not gated by req. */
`ifndef PMA_REF_MODEL_SVH
`define PMA_REF_MODEL_SVH

function automatic pma_resp_t pma_ref_model(input pma_cfg_t [PMA_CNT-1:0]       cfg_tbl,
                                            input logic [PMA_CNT-1:0][XLEN-1:0] adr_tbl,
                                            input pma_req_t                     req);
  pma_resp_t       rsp;
  pma_cfg_t        san [PMA_CNT];
  pma_cfg_t        m;
  logic [PLEN-3:0] a;
  logic [PLEN-3:0] lb;
  logic [PLEN-3:0] ub;
  logic [PLEN-3:0] prev_ub;
  logic [PLEN-1:0] nb;
  logic [PLEN-1:0] last;
  int              n;
  int              hit;

  // Sizes above QWORD count as one byte
  nb      = (req.size <= QWORD) ? (PLEN'(1) << req.size) : PLEN'(1);
  last    = req.adr + nb - PLEN'(1);
  prev_ub = '0;
  hit     = -1;
  for (int i = 0; i < PMA_CNT; i++) begin
    san[i] = cfg_tbl[i];
    if (cfg_tbl[i].mem_type == MEM_TYPE_EMPTY) begin
      san[i].mem_type = MEM_TYPE_IO;
      san[i].amo_type = AMO_TYPE_NONE;
      san[i].r        = 1'b0;
      san[i].w        = 1'b0;
      san[i].x        = 1'b0;
    end
    if (cfg_tbl[i].mem_type != MEM_TYPE_MAIN) san[i].cacheable = 1'b0;
    if (!san[i].cacheable) san[i].coherent = 1'b0;
    if (cfg_tbl[i].mem_type != MEM_TYPE_IO) begin
      san[i].idem_rd = 1'b1;
      san[i].idem_wr = 1'b1;
    end
    // Region bounds in words
    a = adr_tbl[i][PLEN-3:0];
    case (cfg_tbl[i].mode)
      TOR: begin
        lb = prev_ub;
        ub = a;
      end
      NA4: begin
        lb = a;
        ub = a + 1'b1;
      end
      NAPOT: begin
        n = 1;
        while ((n <= PLEN-2) && a[n-1]) n++;
        lb = (a >> n) << n;
        ub = ((a + ({{(PLEN-3){1'b0}}, 1'b1} << n)) >> n) << n;
      end
      default: begin
        lb = '0;
        ub = a;
      end
    endcase
    if ((hit < 0) && (cfg_tbl[i].mode != OFF) &&
        (req.adr[PLEN-1:2] >= lb) && (last[PLEN-1:2] < ub)) hit = i;
    prev_ub = ub;
  end

  m   = (hit < 0) ? san[0] : san[hit];
  rsp = '0;
  rsp.valid      = req.req;
  rsp.pma        = m;
  rsp.exception  = req.req & ((hit < 0) | (req.instr & ~m.x) |
                              (req.we & ~m.w) | (~req.we & ~m.r));
  rsp.misaligned = req.req & ((req.adr % nb) != 0) & ~m.misalign_ok;
  if (req.req && !rsp.exception && !rsp.misaligned) begin
    rsp.is_cache = m.cacheable;
    rsp.is_tcm   = (m.mem_type == MEM_TYPE_TCM);
    rsp.is_ext   = ~m.cacheable & (m.mem_type != MEM_TYPE_TCM);
  end
  return rsp;
endfunction

`endif

// File: verification/riscv_pma_unit_tb.sv
/* Testbench for the PMA stage; every driven cycle is checked one edge later against
   a reference model on a shadow table. Random stimulus uses a fixed seed. */
`default_nettype none

module riscv_pma_unit_tb
  import riscv_pma_pkg::*;
();

  `include "pma_ref_model.svh"

  // Run length, used by the watchdog
  localparam int DIRECTED_CYCLES = 300;
  localparam int RANDOM_REQS     = 400;
  localparam int TIMEOUT         = (DIRECTED_CYCLES + RANDOM_REQS) * 20;

  logic                         clk;
  logic                         rst_n;
  logic                         cfg_wr_cfg;
  logic                         cfg_wr_adr;
  logic [PMA_IDX_W-1:0]         cfg_idx;
  logic [XLEN-1:0]              cfg_wdata;
  pma_req_t                     req;
  pma_resp_t                    resp;

  // Shadow of the attribute table
  pma_cfg_t [PMA_CNT-1:0]       shadow_cfg;
  logic [PMA_CNT-1:0][XLEN-1:0] shadow_adr;

  // Expected responses and the cycle each is due
  pma_resp_t                    exp_q[$];
  int unsigned                  due_q[$];
  pma_resp_t                    exp_r;
  int unsigned                  cyc = 0;
  int                           chk_cnt = 0;
  int                           err_cnt = 0;
  int                           test_chk0;
  int                           test_err0;

  tb_clk_gen i_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  riscv_pma_unit i_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .cfg_wr_cfg_i (cfg_wr_cfg),
    .cfg_wr_adr_i (cfg_wr_adr),
    .cfg_idx_i    (cfg_idx),
    .cfg_wdata_i  (cfg_wdata),
    .req_i        (req),
    .resp_o       (resp)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic pma_req_t make_req(input logic instr, input logic we,
                                        input xfer_size_t size, input logic [PLEN-1:0] adr);
    pma_req_t r;
    r.req   = 1'b1;
    r.instr = instr;
    r.we    = we;
    r.size  = size;
    r.adr   = adr;
    return r;
  endfunction

  // Coherent and AMO set on purpose so sanitizing shows up in pma
  function automatic pma_cfg_t make_cfg(input mem_type_t t, input logic r, input logic w,
                                        input logic x, input logic cache,
                                        input logic mis_ok, input match_mode_t mode);
    pma_cfg_t c;
    c             = '0;
    c.mem_type    = t;
    c.r           = r;
    c.w           = w;
    c.x           = x;
    c.cacheable   = cache;
    c.coherent    = 1'b1;
    c.misalign_ok = mis_ok;
    c.amo_type    = AMO_TYPE_SWAP;
    c.mode        = mode;
    return c;
  endfunction

  // Word-unit address for a power-of-two region of at least 8 bytes
  function automatic logic [XLEN-1:0] napot_word(input logic [XLEN-1:0] base,
                                                 input logic [XLEN-1:0] bytes);
    return (base | ((bytes >> 1) - 1)) >> 2;
  endfunction

  // One driven cycle; expected result comes from the table before any write
  task automatic step(input pma_req_t r, input logic wcfg, input logic wadr,
                      input logic [PMA_IDX_W-1:0] idx, input logic [XLEN-1:0] data);
    @(posedge clk);
    #1;
    req        = r;
    cfg_wr_cfg = wcfg;
    cfg_wr_adr = wadr;
    cfg_idx    = idx;
    cfg_wdata  = data;
    exp_q.push_back(pma_ref_model(shadow_cfg, shadow_adr, r));
    due_q.push_back(cyc + 1);
    if (wcfg) begin
      shadow_cfg[idx] = pma_cfg_t'(data[PMA_CFG_W-1:0]);
    end
    if (wadr) begin
      shadow_adr[idx] = data;
    end
  endtask

  // Config word, then address word
  task automatic write_entry(input logic [PMA_IDX_W-1:0] idx, input pma_cfg_t c,
                             input logic [XLEN-1:0] adr_word);
    step('0, 1'b1, 1'b0, idx, {{(XLEN-PMA_CFG_W){1'b0}}, c});
    step('0, 1'b0, 1'b1, idx, adr_word);
  endtask

  task automatic issue_access(input logic instr, input logic we, input xfer_size_t size,
                              input logic [PLEN-1:0] adr);
    step(make_req(instr, we, size, adr), 1'b0, 1'b0, '0, '0);
  endtask

  task automatic open_test();
    test_chk0 = chk_cnt;
    test_err0 = err_cnt;
  endtask

  // Idle the inputs and wait for every pending response
  task automatic close_test(input string name);
    @(posedge clk);
    #1;
    req        = '0;
    cfg_wr_cfg = 1'b0;
    cfg_wr_adr = 1'b0;
    while (exp_q.size() > 0) @(negedge clk);
    $display("%-16s %0d checks, %0d errors", name, chk_cnt - test_chk0,
             err_cnt - test_err0);
  endtask

  task automatic report_mismatch(input string field, input logic [31:0] got,
                                 input logic [31:0] expv);
    $display("Mismatch at %0t: %s is %0h, expected %0h", $time, field, got, expv);
    err_cnt++;
  endtask

  //////////////////////////////////////////////////
  // Response checker
  //////////////////////////////////////////////////

  always @(posedge clk) cyc <= cyc + 1;

  // Mid-cycle, inputs and resp_o both settled
  always @(negedge clk) begin
    if ((due_q.size() > 0) && (due_q[0] == cyc)) begin
      exp_r = exp_q.pop_front();
      void'(due_q.pop_front());
      chk_cnt++;
      if (resp.valid !== exp_r.valid) report_mismatch("valid", resp.valid, exp_r.valid);
      if (resp.pma !== exp_r.pma) report_mismatch("pma", resp.pma, exp_r.pma);
      if (resp.exception !== exp_r.exception) begin
        report_mismatch("exception", resp.exception, exp_r.exception);
      end
      if (resp.misaligned !== exp_r.misaligned) begin
        report_mismatch("misaligned", resp.misaligned, exp_r.misaligned);
      end
      if (resp.is_cache !== exp_r.is_cache) begin
        report_mismatch("is_cache", resp.is_cache, exp_r.is_cache);
      end
      if (resp.is_ext !== exp_r.is_ext) report_mismatch("is_ext", resp.is_ext, exp_r.is_ext);
      if (resp.is_tcm !== exp_r.is_tcm) report_mismatch("is_tcm", resp.is_tcm, exp_r.is_tcm);
    end
  end

  // Watchdog
  initial begin
    #(TIMEOUT);
    $display("Timeout: run did not finish within %0d time units", TIMEOUT);
    $display("TEST FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin : main
    int       offs [5];
    pma_req_t r;
    logic     wcfg;
    logic     wadr;

    offs       = '{0, 1, 2, 3, 6};
    // Misaligned faulting write held through reset, must not reach resp_o
    req        = make_req(1'b0, 1'b1, WORD, 32'h0000_1001);
    cfg_wr_cfg = 1'b0;
    cfg_wr_adr = 1'b0;
    cfg_idx    = '0;
    cfg_wdata  = '0;
    for (int i = 0; i < PMA_CNT; i++) begin
      shadow_cfg[i] = PMA_CFG_RST;
      shadow_adr[i] = '0;
    end
    void'($urandom(32'h4eb9_edb5));

    // Reset: quiet outputs, then everything faults on an all-OFF table
    open_test();
    wait (rst_n === 1'b1);
    req = '0;
    @(negedge clk);
    chk_cnt++;
    if (resp.valid !== 1'b0) report_mismatch("valid after reset", resp.valid, 0);
    if ({resp.exception, resp.misaligned, resp.is_cache, resp.is_ext, resp.is_tcm} !== '0) begin
      report_mismatch("flags after reset", {resp.exception, resp.misaligned, resp.is_cache,
                      resp.is_ext, resp.is_tcm}, 0);
    end
    issue_access(1'b0, 1'b0, WORD, 32'h0000_1000);
    issue_access(1'b1, 1'b0, WORD, 32'h0000_0000);
    issue_access(1'b0, 1'b1, BYTE, 32'h8000_0003);
    close_test("reset");

    // NA4 and NAPOT, permissions per kind of access
    open_test();
    write_entry(0, make_cfg(MEM_TYPE_MAIN, 1, 0, 0, 0, 0, NA4), 32'h0000_0040);
    write_entry(1, make_cfg(MEM_TYPE_IO, 1, 1, 0, 0, 0, NAPOT), napot_word(32'h2000, 32'h1000));
    write_entry(2, make_cfg(MEM_TYPE_MAIN, 1, 0, 1, 1, 0, NAPOT),
                napot_word(32'h1_0000, 32'h1_0000));
    // EMPTY with full permissions, must still fault
    write_entry(3, make_cfg(MEM_TYPE_EMPTY, 1, 1, 1, 1, 0, NAPOT),
                napot_word(32'h4_0000, 32'h100));
    issue_access(1'b0, 1'b0, WORD, 32'h0000_0100);
    issue_access(1'b0, 1'b1, WORD, 32'h0000_0100);
    issue_access(1'b1, 1'b0, WORD, 32'h0000_0100);
    issue_access(1'b0, 1'b0, WORD, 32'h0000_0104);
    issue_access(1'b0, 1'b0, WORD, 32'h0000_00FC);
    issue_access(1'b0, 1'b0, DWORD, 32'h0000_0100);
    issue_access(1'b0, 1'b1, WORD, 32'h0000_2FFC);
    issue_access(1'b0, 1'b0, WORD, 32'h0000_2000);
    issue_access(1'b1, 1'b0, WORD, 32'h0000_2800);
    issue_access(1'b0, 1'b0, WORD, 32'h0000_3000);
    issue_access(1'b0, 1'b0, WORD, 32'h0001_FFFC);
    issue_access(1'b1, 1'b0, WORD, 32'h0001_0000);
    issue_access(1'b0, 1'b1, WORD, 32'h0001_8000);
    issue_access(1'b0, 1'b0, WORD, 32'h0004_0000);
    issue_access(1'b0, 1'b1, WORD, 32'h0004_00FC);
    issue_access(1'b1, 1'b0, WORD, 32'h0004_0010);
    close_test("na4_napot");

    // TOR chain under a wide NAPOT; lowest index that holds the access wins
    open_test();
    write_entry(0, make_cfg(MEM_TYPE_MAIN, 1, 1, 1, 1, 0, TOR), 32'h0000_0400);
    write_entry(1, make_cfg(MEM_TYPE_IO, 1, 1, 0, 1, 0, TOR), 32'h0000_0800);
    write_entry(2, make_cfg(MEM_TYPE_TCM, 1, 1, 1, 0, 0, NAPOT), napot_word(32'h0, 32'h4000));
    write_entry(3, make_cfg(MEM_TYPE_MAIN, 1, 0, 0, 0, 0, TOR), 32'h0000_1400);
    issue_access(1'b0, 1'b0, WORD, 32'h0000_0FFC);
    issue_access(1'b0, 1'b1, WORD, 32'h0000_1000);
    issue_access(1'b1, 1'b0, WORD, 32'h0000_1004);
    issue_access(1'b0, 1'b0, WORD, 32'h0000_0FFE);
    issue_access(1'b0, 1'b0, HWORD, 32'h0000_1FFF);
    issue_access(1'b0, 1'b0, WORD, 32'h0000_2000);
    issue_access(1'b0, 1'b0, WORD, 32'h0000_3FFE);
    issue_access(1'b0, 1'b0, DWORD, 32'h0000_4FF8);
    issue_access(1'b0, 1'b0, DWORD, 32'h0000_4FFC);
    issue_access(1'b0, 1'b1, WORD, 32'h0000_4000);
    issue_access(1'b0, 1'b0, BYTE, 32'h0000_5000);
    close_test("tor_priority");

    // Every size at odd offsets, misalign_ok set in entry 0 only
    open_test();
    write_entry(0, make_cfg(MEM_TYPE_MAIN, 1, 1, 1, 1, 1, NAPOT), napot_word(32'h8000, 32'h1000));
    write_entry(1, make_cfg(MEM_TYPE_MAIN, 1, 1, 1, 1, 0, NAPOT), napot_word(32'h9000, 32'h1000));
    write_entry(2, make_cfg(MEM_TYPE_IO, 1, 1, 0, 0, 0, OFF), 32'h0);
    write_entry(3, make_cfg(MEM_TYPE_IO, 1, 1, 0, 0, 0, OFF), 32'h0);
    for (int s = 0; s <= 4; s++) begin
      for (int k = 0; k < 5; k++) begin
        issue_access(1'b0, k[0], xfer_size_t'(3'(s)), 32'h0000_8100 + offs[k]);
        issue_access(1'b0, k[0], xfer_size_t'(3'(s)), 32'h0000_9100 + offs[k]);
      end
    end
    close_test("misalign");

    // One region of each kind
    open_test();
    write_entry(0, make_cfg(MEM_TYPE_MAIN, 1, 1, 1, 1, 0, NAPOT), napot_word(32'hA000, 32'h1000));
    write_entry(1, make_cfg(MEM_TYPE_MAIN, 1, 1, 1, 0, 0, NAPOT), napot_word(32'hB000, 32'h1000));
    write_entry(2, make_cfg(MEM_TYPE_IO, 1, 1, 1, 1, 0, NAPOT), napot_word(32'hC000, 32'h1000));
    write_entry(3, make_cfg(MEM_TYPE_TCM, 1, 1, 1, 1, 0, NAPOT), napot_word(32'hD000, 32'h1000));
    for (int e = 0; e < 4; e++) begin
      issue_access(1'b0, 1'b0, WORD, 32'h0000_A010 + 32'(e) * 32'h1000);
      issue_access(1'b0, 1'b1, WORD, 32'h0000_A020 + 32'(e) * 32'h1000);
      issue_access(1'b1, 1'b0, WORD, 32'h0000_A030 + 32'(e) * 32'h1000);
    end
    close_test("classify");

    // Random table, random requests, rewrites in the same cycles
    open_test();
    for (int i = 0; i < PMA_CNT; i++) begin
      write_entry(PMA_IDX_W'(i), pma_cfg_t'(14'($urandom())), $urandom() & 32'h0000_3FFF);
    end
    for (int k = 0; k < RANDOM_REQS; k++) begin
      r    = make_req(1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)),
                      xfer_size_t'(3'($urandom_range(0, 4))),
                      PLEN'($urandom_range(0, 32'h0001_0000)));
      wcfg = ($urandom_range(0, 3) == 0);
      wadr = ($urandom_range(0, 3) == 0);
      step(r, wcfg, wadr, PMA_IDX_W'($urandom_range(0, PMA_CNT-1)),
           $urandom() & 32'h0000_3FFF);
    end
    close_test("random");

    $display("Done: %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: riscv_pma_unit.f
+incdir+include
verilog/riscv_pma_pkg.sv
verilog/riscv_pma_regs.sv
verilog/riscv_misalign_det.sv
verilog/riscv_pmachk.sv
verilog/riscv_pma_unit.sv
verification/tb_clk_gen.sv
verification/riscv_pma_unit_tb.sv

// File: Makefile
TOP := riscv_pma_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f riscv_pma_unit.f --top-module $(TOP) -o V$(TOP)

# Fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
